//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_axi_burst_writer
FILELIST  = axi_burst_writer.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SOURCES   = $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the simulator exit code is not used
run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axi_burst_writer.f
+incdir+rtl
rtl/axi_wr_pkg.sv
rtl/wr_cmd_regs.sv
rtl/burst_planner.sv
rtl/wr_burst_seq.sv
rtl/axi_burst_writer.sv
verif/axi_slave_model.sv
verif/tb_axi_burst_writer.sv

//--- rtl/axi_burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

// write-only AXI4 INCR burst master
module axi_burst_writer
    import axi_wr_pkg::*;
(
    input  wire logic   aclk,
    input  wire logic   aresetn,

    // command
    input  wire logic   user_w_start,
    input  addr_t       user_w_addr,
    input  len_t        user_w_len,
    output logic        user_w_free,
    output wr_err_t     user_w_cmd_error,

    // data store, fwft style
    input  data_t       user_w_data,
    input  strb_t       user_w_strb,
    input  beats_t      user_w_data_cnt,
    output logic        user_w_wready,

    // response
    input  wire logic   user_w_bready,
    output logic        user_w_bvalid,
    output resp_t       user_w_status,

    // AXI4 write channels
    output addr_t       m_axi_awaddr,
    output len_t        m_axi_awlen,
    output logic        m_axi_awvalid,
    input  wire logic   m_axi_awready,
    output data_t       m_axi_wdata,
    output strb_t       m_axi_wstrb,
    output logic        m_axi_wvalid,
    output logic        m_axi_wlast,
    input  wire logic   m_axi_wready,
    input  resp_t       m_axi_bresp,
    input  wire logic   m_axi_bvalid,
    output logic        m_axi_bready
);

    wr_burst_t  cmd;            // captured user command
    wr_burst_t  cur_burst;      // burst on the bus
    wr_burst_t  first_burst;
    wr_burst_t  rem_burst;
    logic       split;
    wr_err_t    err;
    logic       rem_pending;
    logic       cmd_valid;
    logic       check_done;
    logic       take_remainder;
    logic       cmd_done;

    wr_cmd_regs u_cmd_regs (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .user_w_start     (user_w_start),
        .user_w_addr      (user_w_addr),
        .user_w_len       (user_w_len),
        .first_burst      (first_burst),
        .rem_burst        (rem_burst),
        .split            (split),
        .err              (err),
        .check_done       (check_done),
        .take_remainder   (take_remainder),
        .cmd_done         (cmd_done),
        .cmd              (cmd),
        .cur_burst        (cur_burst),
        .rem_pending      (rem_pending),
        .cmd_valid        (cmd_valid),
        .user_w_free      (user_w_free),
        .user_w_cmd_error (user_w_cmd_error)
    );

    burst_planner u_planner (
        .cmd         (cmd),
        .data_cnt    (user_w_data_cnt),
        .first_burst (first_burst),
        .rem_burst   (rem_burst),
        .split       (split),
        .err         (err)
    );

    wr_burst_seq u_seq (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .cmd_valid      (cmd_valid),
        .rem_pending    (rem_pending),
        .cur_burst      (cur_burst),
        .err            (err),
        .user_w_data    (user_w_data),
        .user_w_strb    (user_w_strb),
        .user_w_bready  (user_w_bready),
        .m_axi_awready  (m_axi_awready),
        .m_axi_wready   (m_axi_wready),
        .m_axi_bresp    (m_axi_bresp),
        .m_axi_bvalid   (m_axi_bvalid),
        .check_done     (check_done),
        .take_remainder (take_remainder),
        .cmd_done       (cmd_done),
        .m_axi_awaddr   (m_axi_awaddr),
        .m_axi_awlen    (m_axi_awlen),
        .m_axi_awvalid  (m_axi_awvalid),
        .m_axi_wdata    (m_axi_wdata),
        .m_axi_wstrb    (m_axi_wstrb),
        .m_axi_wvalid   (m_axi_wvalid),
        .m_axi_wlast    (m_axi_wlast),
        .m_axi_bready   (m_axi_bready),
        .user_w_wready  (user_w_wready),
        .user_w_bvalid  (user_w_bvalid),
        .user_w_status  (user_w_status)
    );

endmodule

`default_nettype wire

//--- rtl/axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

`include "axi_wr_settings.svh"

    typedef logic [`AXI_ADDR_W-1:0]     addr_t;     // byte address
    typedef logic [`AXI_DATA_W-1:0]     data_t;     // one beat
    typedef logic [`WR_BEAT_BYTES-1:0]  strb_t;     // byte strobes
    typedef logic [`AXI_LEN_W-1:0]      len_t;      // beats minus one

    // 0..512 beats, one page worth plus the zero case
    typedef logic [$clog2(`WR_PAGE_BYTES / `WR_BEAT_BYTES):0] beats_t;

    typedef logic [1:0]                 resp_t;     // okay, exokay, slverr, decerr

    // one burst as it goes out on AW
    typedef struct packed {
        addr_t  addr;
        len_t   len;
    } wr_burst_t;

    // command check result, held for the user until the next accept
    typedef struct packed {
        logic   misalign;       // addr not on a beat boundary
        logic   short_data;     // store holds fewer words than len + 1
    } wr_err_t;

    // one-hot write FSM
    typedef enum logic [4:0] {
        ST_IDLE  = 5'b00001,
        ST_CHECK = 5'b00010,
        ST_ADDR  = 5'b00100,
        ST_DATA  = 5'b01000,
        ST_RESP  = 5'b10000
    } wr_state_t;

endpackage

`default_nettype wire

//--- rtl/axi_wr_settings.svh
`ifndef AXI_WR_SETTINGS_SVH
`define AXI_WR_SETTINGS_SVH

// AXI4 write master widths

// byte address width on AW
`define AXI_ADDR_W      32

// beat width in bits, every beat is full width
`define AXI_DATA_W      64

`define AXI_LEN_W       8       // AxLEN, beats minus one

// 4 KiB boundary that no burst may cross
`define WR_PAGE_BYTES   4096

// bytes moved per beat, also the address alignment
`define WR_BEAT_BYTES   (`AXI_DATA_W / 8)

// with 8 byte beats a page holds 512 beats and a command at most 256,
// so a command is split no more than once

`endif

//--- rtl/burst_planner.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_settings.svh"

// purely combinational, looks at the held command and the data store level
module burst_planner
    import axi_wr_pkg::*;
(
    input  wr_burst_t   cmd,
    input  beats_t      data_cnt,       // words waiting in the user store
    output wr_burst_t   first_burst,
    output wr_burst_t   rem_burst,
    output logic        split,
    output wr_err_t     err
);

    localparam int ADDR_W     = `AXI_ADDR_W;
    localparam int PAGE_W     = $clog2(`WR_PAGE_BYTES);    // 12
    localparam int OFF_W      = PAGE_W + 1;                 // holds a full page
    localparam int BEAT_SHIFT = $clog2(`WR_BEAT_BYTES);    // 3

    logic [PAGE_W-1:0]  page_off;       // byte offset inside the page
    logic [OFF_W-1:0]   bytes_left;     // up to the boundary, 1..4096
    beats_t             beats_left;
    beats_t             beats_total;    // len + 1
    beats_t             beats_rest;     // what spills into the next page
    addr_t              page_base;

    assign page_off    = cmd.addr[PAGE_W-1:0];
    assign bytes_left  = OFF_W'(`WR_PAGE_BYTES) - {1'b0, page_off};
    assign beats_left  = beats_t'(bytes_left >> BEAT_SHIFT);   // floor, misaligned is an error anyway
    assign beats_total = beats_t'(cmd.len) + beats_t'(1);
    assign beats_rest  = beats_total - beats_left;              // only meaningful when split
    assign page_base   = {cmd.addr[ADDR_W-1:PAGE_W], {PAGE_W{1'b0}}};

    // 256 beats max against 512 per page, so one cut at most
    assign split = (beats_total > beats_left);

    always_comb
    begin
        first_burst.addr = cmd.addr;
        first_burst.len  = cmd.len;
        rem_burst.addr   = page_base + addr_t'(`WR_PAGE_BYTES);   // base of the next page
        rem_burst.len    = '0;

        if (split)
        begin
            first_burst.len = len_t'(beats_left - beats_t'(1));   // end right at the boundary
            rem_burst.len   = len_t'(beats_rest - beats_t'(1));
        end
    end

    // checked once, the seq samples these in ST_CHECK
    always_comb
    begin
        err.misalign   = |cmd.addr[BEAT_SHIFT-1:0];
        err.short_data = (data_cnt < beats_total);   // whole command must be there upfront
    end

endmodule

`default_nettype wire

//--- rtl/wr_burst_seq.sv
`timescale 1ns/1ps
`default_nettype none

// write FSM, drives AW, W and B and tells the command regs where it is
module wr_burst_seq
    import axi_wr_pkg::*;
(
    input  wire logic   aclk,
    input  wire logic   aresetn,

    input  wire logic   cmd_valid,
    input  wire logic   rem_pending,
    input  wr_burst_t   cur_burst,
    input  wr_err_t     err,

    input  data_t       user_w_data,    // fwft head of the user store
    input  strb_t       user_w_strb,
    input  wire logic   user_w_bready,

    input  wire logic   m_axi_awready,
    input  wire logic   m_axi_wready,
    input  resp_t       m_axi_bresp,
    input  wire logic   m_axi_bvalid,

    output logic        check_done,
    output logic        take_remainder,
    output logic        cmd_done,

    output addr_t       m_axi_awaddr,
    output len_t        m_axi_awlen,
    output logic        m_axi_awvalid,
    output data_t       m_axi_wdata,
    output strb_t       m_axi_wstrb,
    output logic        m_axi_wvalid,
    output logic        m_axi_wlast,
    output logic        m_axi_bready,

    output logic        user_w_wready,  // pop
    output logic        user_w_bvalid,
    output resp_t       user_w_status
);

    wr_state_t  state_cs;
    wr_state_t  state_ns;
    len_t       beat_cnt;       // beats already accepted in this burst
    logic       last_beat;
    logic       w_hs;
    logic       b_hs;
    logic       cmd_bad;

    assign last_beat = (beat_cnt == cur_burst.len);
    assign w_hs      = m_axi_wvalid & m_axi_wready;
    assign b_hs      = m_axi_bvalid & m_axi_bready;
    assign cmd_bad   = |err;

    always_ff @(posedge aclk)
    begin
        if (~aresetn)
            state_cs <= ST_IDLE;
        else
            state_cs <= state_ns;
    end

    always_ff @(posedge aclk)
    begin
        if (~aresetn)
            beat_cnt <= '0;
        else if (state_cs != ST_DATA)
            beat_cnt <= '0;                 // restart for each burst
        else if (w_hs)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_comb
    begin
        state_ns = state_cs;
        case (state_cs)
            ST_IDLE:  if (cmd_valid) state_ns = ST_CHECK;
            ST_CHECK: state_ns = cmd_bad ? ST_IDLE : ST_ADDR;
            ST_ADDR:  if (m_axi_awready) state_ns = ST_DATA;
            ST_DATA:  if (w_hs && last_beat) state_ns = ST_RESP;
            ST_RESP:
            begin
                if (b_hs)
                    state_ns = rem_pending ? ST_ADDR : ST_IDLE;   // second half skips the check
            end
            default:  state_ns = ST_IDLE;
        endcase
    end

    // strobes back to the command regs
    assign check_done     = (state_cs == ST_CHECK);
    assign take_remainder = (state_cs == ST_RESP) & b_hs & rem_pending;
    assign cmd_done       = ((state_cs == ST_CHECK) & cmd_bad) |
                            ((state_cs == ST_RESP) & b_hs & ~rem_pending);

    // AW, fields come straight from registers so they hold under stall
    assign m_axi_awvalid = (state_cs == ST_ADDR);
    assign m_axi_awaddr  = cur_burst.addr;
    assign m_axi_awlen   = cur_burst.len;

    // W, data was counted upfront so wvalid never drops mid burst
    assign m_axi_wvalid  = (state_cs == ST_DATA);
    assign m_axi_wdata   = user_w_data;
    assign m_axi_wstrb   = user_w_strb;
    assign m_axi_wlast   = (state_cs == ST_DATA) & last_beat;
    assign user_w_wready = (state_cs == ST_DATA) & m_axi_wready;   // pop exactly on handshake

    // B passed through to the user
    assign m_axi_bready  = (state_cs == ST_RESP) & user_w_bready;
    assign user_w_bvalid = (state_cs == ST_RESP) & m_axi_bvalid;
    assign user_w_status = (state_cs == ST_RESP) ? m_axi_bresp : resp_t'(0);

endmodule

`default_nettype wire

//--- rtl/wr_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

// command side state of the writer: what the user asked for, which burst
// is on the bus now, and whether a second half is still owed
module wr_cmd_regs
    import axi_wr_pkg::*;
(
    input  wire logic   aclk,
    input  wire logic   aresetn,

    input  wire logic   user_w_start,
    input  addr_t       user_w_addr,
    input  len_t        user_w_len,

    input  wr_burst_t   first_burst,    // from the planner
    input  wr_burst_t   rem_burst,
    input  wire logic   split,
    input  wr_err_t     err,

    input  wire logic   check_done,     // seq is in ST_CHECK
    input  wire logic   take_remainder, // second burst starts
    input  wire logic   cmd_done,       // command fully retired or rejected

    output wr_burst_t   cmd,
    output wr_burst_t   cur_burst,
    output logic        rem_pending,
    output logic        cmd_valid,
    output logic        user_w_free,
    output wr_err_t     user_w_cmd_error
);

    logic       accept;
    wr_burst_t  rem_hold;       // second half waits here

    // free only once the whole command, both halves, is gone
    assign user_w_free = ~cmd_valid & ~rem_pending;
    assign accept      = user_w_start & user_w_free;

    // payload registers
    always_ff @(posedge aclk)
    begin
        if (accept)
        begin
            cmd.addr <= user_w_addr;
            cmd.len  <= user_w_len;
        end

        if (check_done)
        begin
            cur_burst <= first_burst;   // valid from ST_ADDR onward
            rem_hold  <= rem_burst;
        end
        else if (take_remainder)
        begin
            cur_burst <= rem_hold;      // next page, no recheck
        end
    end

    // control and status
    always_ff @(posedge aclk)
    begin
        if (~aresetn)
        begin
            cmd_valid        <= 1'b0;
            rem_pending      <= 1'b0;
            user_w_cmd_error <= '0;
        end
        else
        begin
            if (accept)
                cmd_valid <= 1'b1;
            else if (cmd_done)
                cmd_valid <= 1'b0;

            // a rejected command never owes a second burst
            if (check_done)
                rem_pending <= split & ~(|err);
            else if (take_remainder)
                rem_pending <= 1'b0;

            if (accept)
                user_w_cmd_error <= '0;     // fresh command, fresh status
            else if (check_done)
                user_w_cmd_error <= err;
        end
    end

endmodule

`default_nettype wire

//--- verif/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

// AXI4 write slave: random stalls on every signal it owns, a word memory
// and a check that the master holds AW and W while it waits for ready
module axi_slave_model
    import axi_wr_pkg::*;
#(
    parameter int    SEED   = 32'h382b,
    parameter addr_t ERR_LO = 32'h0000_1800,   // bursts starting in here get SLVERR
    parameter addr_t ERR_HI = 32'h0000_1900
)
(
    input  wire logic   aclk,
    input  wire logic   aresetn,
    input  addr_t       awaddr,
    input  len_t        awlen,
    input  wire logic   awvalid,
    output logic        awready,
    input  data_t       wdata,
    input  wire logic   wvalid,
    input  wire logic   wlast,
    output logic        wready,
    output resp_t       bresp,
    output logic        bvalid,
    input  wire logic   bready,
    output logic        protocol_error
);

    data_t      mem [0:1023];   // indexed by addr[12:3], wraps every 8 KiB
    logic [9:0] wr_idx;
    addr_t      burst_addr;     // start of the burst being written
    logic       b_owed;         // wlast taken, B not yet accepted
    logic       aw_stall;       // awvalid without awready last edge
    logic       w_stall;
    addr_t      awaddr_q;
    len_t       awlen_q;
    data_t      wdata_q;
    logic       wlast_q;
    integer     seed = SEED;

    task automatic flag_mismatch(input string name, input logic [63:0] held,
                                 input logic [63:0] now);
        $display("MISMATCH at %0t: %s changed under stall, held %h now %h",
                 $time, name, held, now);
        protocol_error <= 1'b1;
    endtask

    task automatic flag_error(input string msg);
        $display("%s at %0t", msg, $time);
        protocol_error <= 1'b1;
    endtask

    always @(posedge aclk)
    begin
        if (!aresetn)
        begin
            b_owed         <= 1'b0;
            aw_stall       <= 1'b0;
            w_stall        <= 1'b0;
            protocol_error <= 1'b0;
        end
        else
        begin
            if (aw_stall)   // AW has to sit still until awready
            begin
                assert (awvalid) else flag_error("awvalid dropped before awready");
                assert (awaddr == awaddr_q)
                    else flag_mismatch("m_axi_awaddr", 64'(awaddr_q), 64'(awaddr));
                assert (awlen == awlen_q)
                    else flag_mismatch("m_axi_awlen", 64'(awlen_q), 64'(awlen));
            end
            if (w_stall)
            begin
                assert (wvalid) else flag_error("wvalid dropped before wready");
                assert (wdata == wdata_q)
                    else flag_mismatch("m_axi_wdata", wdata_q, wdata);
                assert (wlast == wlast_q)
                    else flag_mismatch("m_axi_wlast", 64'(wlast_q), 64'(wlast));
            end
            aw_stall <= awvalid & ~awready;
            w_stall  <= wvalid & ~wready;

            if (awvalid && awready)
            begin
                burst_addr <= awaddr;
                wr_idx     <= awaddr[12:3];
            end
            if (wvalid && wready)
            begin
                mem[wr_idx] <= wdata;   // strobes are always full
                wr_idx      <= wr_idx + 1'b1;
                if (wlast)
                    b_owed <= 1'b1;
            end
            if (bvalid && bready)
                b_owed <= 1'b0;
        end
        awaddr_q <= awaddr;
        awlen_q  <= awlen;
        wdata_q  <= wdata;
        wlast_q  <= wlast;
    end

    // outputs change on the falling edge only
    always @(negedge aclk)
    begin
        if (!aresetn)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= '0;
        end
        else
        begin
            awready <= ($random(seed) & 3) != 0;   // roughly one stall in four
            wready  <= ($random(seed) & 3) != 0;
            if (!b_owed)
                bvalid <= 1'b0;
            else if (!bvalid && (($random(seed) & 1) != 0))
            begin
                bvalid <= 1'b1;     // held until bready
                bresp  <= (burst_addr >= ERR_LO && burst_addr < ERR_HI) ?
                          resp_t'(2) : resp_t'(0);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_axi_burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_wr_settings.svh"

module tb_axi_burst_writer
    import axi_wr_pkg::*;
();

    localparam int    N_CMDS      = 9;
    localparam int    WATCHDOG_NS = N_CMDS * 2000;
    localparam addr_t ERR_LO      = 32'h0000_1800;
    localparam addr_t ERR_HI      = 32'h0000_1900;

    logic       aclk;
    logic       aresetn;
    logic       user_w_start;
    addr_t      user_w_addr;
    len_t       user_w_len;
    data_t      user_w_data;
    strb_t      user_w_strb;
    beats_t     user_w_data_cnt;
    logic       user_w_bready = 1'b0;
    logic       user_w_free;
    logic       user_w_wready;
    logic       user_w_bvalid;
    resp_t      user_w_status;
    wr_err_t    user_w_cmd_error;
    addr_t      m_axi_awaddr;
    len_t       m_axi_awlen;
    logic       m_axi_awvalid;
    logic       m_axi_awready;
    data_t      m_axi_wdata;
    strb_t      m_axi_wstrb;
    logic       m_axi_wvalid;
    logic       m_axi_wlast;
    logic       m_axi_wready;
    resp_t      m_axi_bresp;
    logic       m_axi_bvalid;
    logic       m_axi_bready;
    logic       slave_error;

    integer     seed = 32'h382b;
    data_t      src_mem [0:1023];   // user data store, fwft at rd_ptr
    beats_t     rd_ptr = '0;
    beats_t     wr_ptr;             // words up to here are visible
    logic       pop_q = 1'b0;       // pop seen on the last rising edge
    wr_burst_t  exp_q[$];           // bursts the current command must issue
    wr_burst_t  exp_b;
    wr_burst_t  aw_burst;           // burst now on W and B
    len_t       w_beat;
    int         b_count = 0;
    wr_err_t    no_err;
    wr_err_t    bad_align;
    wr_err_t    bad_count;
    addr_t      rnd_addr;
    len_t       rnd_len;

    assign user_w_data     = src_mem[rd_ptr];
    assign user_w_strb     = '1;
    assign user_w_data_cnt = wr_ptr - rd_ptr;

    axi_burst_writer u_dut (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .user_w_start     (user_w_start),
        .user_w_addr      (user_w_addr),
        .user_w_len       (user_w_len),
        .user_w_free      (user_w_free),
        .user_w_cmd_error (user_w_cmd_error),
        .user_w_data      (user_w_data),
        .user_w_strb      (user_w_strb),
        .user_w_data_cnt  (user_w_data_cnt),
        .user_w_wready    (user_w_wready),
        .user_w_bready    (user_w_bready),
        .user_w_bvalid    (user_w_bvalid),
        .user_w_status    (user_w_status),
        .m_axi_awaddr     (m_axi_awaddr),
        .m_axi_awlen      (m_axi_awlen),
        .m_axi_awvalid    (m_axi_awvalid),
        .m_axi_awready    (m_axi_awready),
        .m_axi_wdata      (m_axi_wdata),
        .m_axi_wstrb      (m_axi_wstrb),
        .m_axi_wvalid     (m_axi_wvalid),
        .m_axi_wlast      (m_axi_wlast),
        .m_axi_wready     (m_axi_wready),
        .m_axi_bresp      (m_axi_bresp),
        .m_axi_bvalid     (m_axi_bvalid),
        .m_axi_bready     (m_axi_bready)
    );

    axi_slave_model #(
        .SEED   (32'h382b),
        .ERR_LO (ERR_LO),
        .ERR_HI (ERR_HI)
    ) u_slave (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .awaddr         (m_axi_awaddr),
        .awlen          (m_axi_awlen),
        .awvalid        (m_axi_awvalid),
        .awready        (m_axi_awready),
        .wdata          (m_axi_wdata),
        .wvalid         (m_axi_wvalid),
        .wlast          (m_axi_wlast),
        .wready         (m_axi_wready),
        .bresp          (m_axi_bresp),
        .bvalid         (m_axi_bvalid),
        .bready         (m_axi_bready),
        .protocol_error (slave_error)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp)
        else
        begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_failed();
        end
    endtask

    // response the slave owes for a burst, from its error window
    function automatic resp_t expected_resp(input addr_t a);
        if (a >= ERR_LO && a < ERR_HI)
            return resp_t'(2);
        else
            return resp_t'(0);
    endfunction

    // cut a command at the 4 KiB boundary, beats are 8 bytes
    task automatic plan_bursts(input addr_t addr, input len_t len);
        int         total;
        int         room;
        wr_burst_t  b;
        total  = int'(len) + 1;
        room   = (`WR_PAGE_BYTES - int'(addr % `WR_PAGE_BYTES)) / `WR_BEAT_BYTES;
        b.addr = addr;
        b.len  = len;
        if (total > room)
        begin
            b.len = len_t'(room - 1);       // first part ends on the boundary
            exp_q.push_back(b);
            b.addr = addr_t'(addr - (addr % `WR_PAGE_BYTES) + `WR_PAGE_BYTES);
            b.len  = len_t'(total - room - 1);
        end
        exp_q.push_back(b);
    endtask

    task automatic check_reset_outputs();
        check_value("m_axi_awvalid", 64'(m_axi_awvalid), 64'(0));
        check_value("m_axi_wvalid", 64'(m_axi_wvalid), 64'(0));
        check_value("m_axi_wlast", 64'(m_axi_wlast), 64'(0));
        check_value("m_axi_bready", 64'(m_axi_bready), 64'(0));
        check_value("user_w_wready", 64'(user_w_wready), 64'(0));
        check_value("user_w_bvalid", 64'(user_w_bvalid), 64'(0));
        check_value("user_w_free", 64'(user_w_free), 64'(1));
        check_value("user_w_cmd_error", 64'(user_w_cmd_error), 64'(0));
    endtask

    // memory must hold the popped words in order, across a split too
    task automatic check_memory(input addr_t addr, input len_t len, input beats_t start);
        logic [9:0] idx;
        for (int i = 0; i <= int'(len); i++)
        begin
            idx = addr[12:3] + 10'(i);
            check_value("u_slave.mem", u_slave.mem[idx], src_mem[start + beats_t'(i)]);
        end
    endtask

    task automatic run_command(input addr_t addr, input len_t len, input int words,
                               input wr_err_t exp_err);
        beats_t start;
        int     n_bursts;
        int     b_before;
        int     exp_pop;
        while (!user_w_free)
            @(negedge aclk);
        start    = rd_ptr;
        wr_ptr   = rd_ptr + beats_t'(words);    // exactly this many words on offer
        b_before = b_count;
        exp_pop  = (exp_err == no_err) ? int'(len) + 1 : 0;
        if (exp_err == no_err)
            plan_bursts(addr, len);
        n_bursts     = exp_q.size();
        user_w_start = 1'b1;
        user_w_addr  = addr;
        user_w_len   = len;
        @(negedge aclk);
        user_w_start = 1'b0;
        check_value("user_w_free", 64'(user_w_free), 64'(0));     // taken
        while (!user_w_free)
            @(negedge aclk);
        check_value("user_w_cmd_error", 64'(user_w_cmd_error), 64'(exp_err));
        assert (exp_q.size() == 0)
        else
        begin
            $display("command at %h ended before all its AW bursts were issued", addr);
            stop_failed();
        end
        check_value("B response count", 64'(b_count - b_before), 64'(n_bursts));
        check_value("words popped", 64'(rd_ptr - start), 64'(exp_pop));
        if (exp_err == no_err)
            check_memory(addr, len, start);
    endtask

    // bus monitor, samples on the rising edge
    always @(posedge aclk)
    begin
        pop_q <= user_w_wready;
        if (aresetn)
        begin
            assert (!user_w_wready || (m_axi_wvalid && m_axi_wready))
            else
            begin
                $display("user_w_wready popped a word at %0t without a W handshake", $time);
                stop_failed();
            end
            if (m_axi_awvalid && m_axi_awready)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("AW to %h at %0t that no command should issue", m_axi_awaddr, $time);
                    stop_failed();
                end
                else
                begin
                    exp_b = exp_q.pop_front();
                    check_value("m_axi_awaddr", 64'(m_axi_awaddr), 64'(exp_b.addr));
                    check_value("m_axi_awlen", 64'(m_axi_awlen), 64'(exp_b.len));
                    aw_burst = exp_b;
                    w_beat   = '0;
                end
            end
            if (m_axi_wvalid && m_axi_wready)
            begin
                check_value("m_axi_wlast", 64'(m_axi_wlast), 64'(w_beat == aw_burst.len));
                check_value("m_axi_wstrb", 64'(m_axi_wstrb), 64'(8'hff));
                w_beat = w_beat + 1'b1;
            end
            if (m_axi_bvalid && m_axi_bready)
            begin
                check_value("user_w_bvalid", 64'(user_w_bvalid), 64'(1));
                check_value("user_w_status", 64'(user_w_status),
                            64'(expected_resp(aw_burst.addr)));
                b_count++;
            end
        end
    end

    // store pop and random bready, falling edge like all inputs
    always @(negedge aclk)
    begin
        if (pop_q)
            rd_ptr <= rd_ptr + 1'b1;
        user_w_bready <= ($random(seed) & 3) != 0;
    end

    always @(posedge slave_error)
        stop_failed();

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout, commands still running after %0d ns", WATCHDOG_NS);
        stop_failed();
    end

    initial
    begin
        wr_ptr       = '0;
        user_w_start = 1'b0;
        user_w_addr  = '0;
        user_w_len   = '0;
        aresetn      = 1'b0;
        no_err       = wr_err_t'(2'b00);
        bad_align    = wr_err_t'(2'b10);   // misalign
        bad_count    = wr_err_t'(2'b01);   // short_data
        for (int i = 0; i < 1024; i++)
            src_mem[10'(i)] = {$random(seed), $random(seed)};

        repeat (4)
        begin
            @(negedge aclk);
            check_reset_outputs();
        end
        aresetn = 1'b1;
        @(negedge aclk);
        check_reset_outputs();                              // idle right after reset

        run_command(32'h0000_0100, 8'd15, 16, no_err);      // inside one page
        run_command(32'h0000_0FC0, 8'd15, 16, no_err);      // 8 + 8 across 0x1000
        run_command(32'h0000_0F80, 8'd15, 16, no_err);      // ends right on the boundary
        run_command(32'h0000_0204, 8'd3, 4, bad_align);
        run_command(32'h0000_0300, 8'd7, 7, bad_count);     // one word short
        run_command(ERR_LO, 8'd7, 8, no_err);               // SLVERR passed back
        for (int n = 0; n < 3; n++)
        begin
            rnd_addr = {19'd0, 10'($random(seed)), 3'd0};
            rnd_len  = len_t'($random(seed) & 32'h1f);
            run_command(rnd_addr, rnd_len, int'(rnd_len) + 1, no_err);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
